// ==== include/mipi_rx_params.svh ====
`ifndef MIPI_RX_PARAMS_SVH
`define MIPI_RX_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Virtual channel layout
//////////////////////////////////////////////////////////////////////

// Virtual channels reported by the receive controller
`define MIPI_NUM_VC 4

// Bits needed to index one virtual channel
`define MIPI_VC_IDX_W 2

//////////////////////////////////////////////////////////////////////
// Receive controller error word
//////////////////////////////////////////////////////////////////////

`define MIPI_ERR_W 18

// Set by the controller while the link is error-free
`define MIPI_ERR_OK_BIT 9

//////////////////////////////////////////////////////////////////////
// Per-channel counters
//////////////////////////////////////////////////////////////////////

// LED flash counter, top bit drives the LED pair
`define FLASH_CNT_W 5

// Frame counter, wraps silently
`define FRAME_CNT_W 16

`endif

// ==== logic/mipi_rx_pkg.sv ====
`include "mipi_rx_params.svh"

package mipi_rx_pkg;

  //////////////////////////////////////////////////////////////////////
  // Plain vector types
  //////////////////////////////////////////////////////////////////////

  // Index of one virtual channel
  typedef logic [`MIPI_VC_IDX_W-1:0] vc_idx_t;

  // One bit per virtual channel, used for sync and enable vectors
  typedef logic [`MIPI_NUM_VC-1:0] vc_mask_t;

  // Raw error word from the receive controller
  typedef logic [`MIPI_ERR_W-1:0] mipi_err_t;

  typedef logic [`FLASH_CNT_W-1:0] flash_cnt_t;

  typedef logic [`FRAME_CNT_W-1:0] frame_cnt_t;

  //////////////////////////////////////////////////////////////////////
  // Per-channel bundles
  //////////////////////////////////////////////////////////////////////

  // Registered sync of one channel plus the shared link flag
  typedef struct packed {
    logic vsync;
    logic hsync;
    logic err_ok;
  } vc_sync_t;

  // Counter state of one channel
  typedef struct packed {
    flash_cnt_t flash_cnt;
    frame_cnt_t frame_cnt;
  } vc_status_t;

endpackage

// ==== logic/vc_ingress.sv ====
`timescale 1ns/10ps

`include "mipi_rx_params.svh"

// Input stage of the monitor
// Captures the controller outputs on mipi_pclk and builds one sync
// bundle per virtual channel
module vc_ingress
(
  input  logic                                     mipi_pclk,
  input  logic                                     i_arstn,
  input  mipi_rx_pkg::vc_mask_t                    i_vsync,
  input  mipi_rx_pkg::vc_mask_t                    i_hsync,
  input  mipi_rx_pkg::mipi_err_t                   i_err,
  input  mipi_rx_pkg::vc_mask_t                    i_vc_ena,
  output mipi_rx_pkg::vc_sync_t [`MIPI_NUM_VC-1:0] o_sync
);

  //////////////////////////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////////////////////////

  mipi_rx_pkg::vc_mask_t vsync_q;
  mipi_rx_pkg::vc_mask_t hsync_q;
  logic                  err_ok_q;

  // Disabled channels are forced quiet before they reach the monitors
  always_ff @(posedge mipi_pclk)
  begin
    if (!i_arstn)
    begin
      vsync_q  <= '0;
      hsync_q  <= '0;
      err_ok_q <= 1'b0;
    end
    else
    begin
      vsync_q  <= i_vsync & i_vc_ena;
      hsync_q  <= i_hsync & i_vc_ena;
      // Decoded once here and shared by every channel
      err_ok_q <= i_err[`MIPI_ERR_OK_BIT];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Per-channel bundles
  //////////////////////////////////////////////////////////////////////

  genvar k;
  generate
    for (k = 0; k < `MIPI_NUM_VC; k++)
    begin : g_sync
      assign o_sync[k].vsync  = vsync_q[k];
      assign o_sync[k].hsync  = hsync_q[k];
      assign o_sync[k].err_ok = err_ok_q;
    end
  endgenerate

endmodule

// ==== logic/vc_frame_monitor.sv ====
`timescale 1ns/10ps

`include "mipi_rx_params.svh"

// Frame monitor for one virtual channel
// Counts vsync rising edges while the link reports no error
module vc_frame_monitor
(
  input  logic                    mipi_pclk,
  input  logic                    i_arstn,
  input  mipi_rx_pkg::vc_sync_t   i_sync,
  output mipi_rx_pkg::vc_status_t o_status
);

  // Wrap point and reload value of the flash counter
  localparam mipi_rx_pkg::flash_cnt_t FLASH_MAX    = '1;
  localparam mipi_rx_pkg::flash_cnt_t FLASH_RELOAD = mipi_rx_pkg::flash_cnt_t'(1);

  logic                    vsync_prev;
  logic                    vsync_rise;
  mipi_rx_pkg::flash_cnt_t flash_cnt;
  mipi_rx_pkg::frame_cnt_t frame_cnt;

  assign vsync_rise = i_sync.vsync & ~vsync_prev;

  //////////////////////////////////////////////////////////////////////
  // Edge detector and counters
  //////////////////////////////////////////////////////////////////////

  // Everything holds while the link flag is clear
  always_ff @(posedge mipi_pclk)
  begin
    if (!i_arstn)
    begin
      vsync_prev <= 1'b0;
      flash_cnt  <= '0;
      frame_cnt  <= '0;
    end
    else if (i_sync.err_ok)
    begin
      vsync_prev <= i_sync.vsync;
      if (vsync_rise)
      begin
        flash_cnt <= flash_cnt + mipi_rx_pkg::flash_cnt_t'(1);
        frame_cnt <= frame_cnt + mipi_rx_pkg::frame_cnt_t'(1);
      end
      else if (flash_cnt == FLASH_MAX)
      begin
        // Skip zero so the LED keeps blinking after the first frame
        flash_cnt <= FLASH_RELOAD;
      end
    end
  end

  assign o_status.flash_cnt = flash_cnt;
  assign o_status.frame_cnt = frame_cnt;

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Once a frame was seen the flash count never returns to zero.
  // Relies on the edge detector never firing twice in a row at 31
  a_flash_no_zero : assert property (
    @(posedge mipi_pclk)
    (i_arstn && flash_cnt != '0) |=> (flash_cnt != '0)
  )
  else $error("flash counter returned to zero outside reset");

endmodule

// ==== logic/vc_status_select.sv ====
`timescale 1ns/10ps

`include "mipi_rx_params.svh"

// Output stage
// Picks one channel's status and registers the LED pair and frame count
module vc_status_select
(
  input  logic                                       mipi_pclk,
  input  logic                                       i_arstn,
  input  mipi_rx_pkg::vc_status_t [`MIPI_NUM_VC-1:0] i_status,
  input  mipi_rx_pkg::vc_idx_t                       i_vc_sel,
  output logic                                       o_led2,
  output logic                                       o_led3,
  output mipi_rx_pkg::frame_cnt_t                    o_frame_count
);

  mipi_rx_pkg::vc_status_t sel_status;
  logic                    sel_flash_msb;

  //////////////////////////////////////////////////////////////////////
  // Channel mux
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    sel_status = i_status[i_vc_sel];
  end

  // Top flash bit toggles every 16 frames
  assign sel_flash_msb = sel_status.flash_cnt[`FLASH_CNT_W-1];

  //////////////////////////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge mipi_pclk)
  begin
    if (!i_arstn)
    begin
      o_led2        <= 1'b0;
      o_led3        <= 1'b1;
      o_frame_count <= '0;
    end
    else
    begin
      o_led2        <= sel_flash_msb;
      o_led3        <= ~sel_flash_msb;
      o_frame_count <= sel_status.frame_cnt;
    end
  end

  // LED pair is complementary in and out of reset
  a_led_complement : assert property (
    @(posedge mipi_pclk) disable iff (!i_arstn)
    o_led2 != o_led3
  )
  else $error("LED outputs are not complementary");

endmodule

// ==== logic/mipi_rx_monitor.sv ====
`timescale 1ns/10ps

`include "mipi_rx_params.svh"

// MIPI receive monitor, top level
// Ingress registers -> per-channel frame monitors -> output select
module mipi_rx_monitor
(
  input  logic                    mipi_pclk,
  input  logic                    i_arstn,
  input  mipi_rx_pkg::vc_mask_t   i_vsync,
  input  mipi_rx_pkg::vc_mask_t   i_hsync,
  input  mipi_rx_pkg::mipi_err_t  i_err,
  input  mipi_rx_pkg::vc_mask_t   i_vc_ena,
  input  mipi_rx_pkg::vc_idx_t    i_vc_sel,
  output logic                    o_led2,
  output logic                    o_led3,
  output mipi_rx_pkg::frame_cnt_t o_frame_count
);

  mipi_rx_pkg::vc_sync_t   [`MIPI_NUM_VC-1:0] vc_sync;
  mipi_rx_pkg::vc_status_t [`MIPI_NUM_VC-1:0] vc_status;

  //////////////////////////////////////////////////////////////////////
  // Input stage
  //////////////////////////////////////////////////////////////////////

  vc_ingress u_ingress
  (
    .mipi_pclk (mipi_pclk),
    .i_arstn   (i_arstn),
    .i_vsync   (i_vsync),
    .i_hsync   (i_hsync),
    .i_err     (i_err),
    .i_vc_ena  (i_vc_ena),
    .o_sync    (vc_sync)
  );

  //////////////////////////////////////////////////////////////////////
  // One monitor per virtual channel
  //////////////////////////////////////////////////////////////////////

  genvar k;
  generate
    for (k = 0; k < `MIPI_NUM_VC; k++)
    begin : g_vc
      vc_frame_monitor u_monitor
      (
        .mipi_pclk (mipi_pclk),
        .i_arstn   (i_arstn),
        .i_sync    (vc_sync[k]),
        .o_status  (vc_status[k])
      );
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////////////////////////

  vc_status_select u_select
  (
    .mipi_pclk     (mipi_pclk),
    .i_arstn       (i_arstn),
    .i_status      (vc_status),
    .i_vc_sel      (i_vc_sel),
    .o_led2        (o_led2),
    .o_led3        (o_led3),
    .o_frame_count (o_frame_count)
  );

endmodule

// ==== sim/tb_mipi_rx_monitor.sv ====
`timescale 1ns/10ps

`include "mipi_rx_params.svh"

module tb_mipi_rx_monitor;

  localparam int WAIT_LIMIT = 40;
  localparam int MIN_IDLE   = 3;

  logic                    mipi_pclk = 1'b0;
  logic                    i_arstn;
  mipi_rx_pkg::vc_mask_t   i_vsync;
  mipi_rx_pkg::vc_mask_t   i_hsync;
  mipi_rx_pkg::mipi_err_t  i_err;
  mipi_rx_pkg::vc_mask_t   i_vc_ena;
  mipi_rx_pkg::vc_idx_t    i_vc_sel;
  logic                    o_led2;
  logic                    o_led3;
  mipi_rx_pkg::frame_cnt_t o_frame_count;

  // Reference tallies per channel, kept by the rules of the monitor
  int tally_frames [`MIPI_NUM_VC];
  int tally_flash  [`MIPI_NUM_VC];
  int error_count;
  int timeout_count;

  mipi_rx_monitor i_dut
  (
    .mipi_pclk     (mipi_pclk),
    .i_arstn       (i_arstn),
    .i_vsync       (i_vsync),
    .i_hsync       (i_hsync),
    .i_err         (i_err),
    .i_vc_ena      (i_vc_ena),
    .i_vc_sel      (i_vc_sel),
    .o_led2        (o_led2),
    .o_led3        (o_led3),
    .o_frame_count (o_frame_count)
  );

  // 8 ns clock period
  always #4 mipi_pclk = ~mipi_pclk;

  //////////////////////////////////////////////////////////////////////
  // Reference model and checking
  //////////////////////////////////////////////////////////////////////

  // One counted vsync rise; flash reloads 1 during the idle gap after 31
  function automatic void record_frame(int ch);
    tally_frames[ch] = tally_frames[ch] + 1;
    tally_flash[ch]  = tally_flash[ch] + 1;
    if (tally_flash[ch] == 31)
    begin
      tally_flash[ch] = 1;
    end
  endfunction

  task automatic check_value(string what, int actual, int expected);
    if (actual != expected)
    begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
      error_count++;
    end
  endtask

  // Sampled on the falling edge, where outputs are stable
  task automatic wait_for_outputs(int exp_count, int exp_led, string what);
    int   cycles;
    logic matched;
    cycles  = 0;
    matched = 1'b0;
    while (!matched && cycles < WAIT_LIMIT)
    begin
      @(negedge mipi_pclk);
      cycles++;
      if (cycles >= MIN_IDLE && int'(o_frame_count) == exp_count && int'(o_led2) == exp_led)
      begin
        matched = 1'b1;
      end
    end
    if (!matched)
    begin
      $display("Timeout at %0t: outputs never settled for %s", $time, what);
      timeout_count++;
    end
    check_value({what, ": o_frame_count"}, int'(o_frame_count), exp_count);
    check_value({what, ": o_led2"}, int'(o_led2), exp_led);
    check_value({what, ": o_led3"}, int'(o_led3), 1 - exp_led);
  endtask

  task automatic check_selected(int ch, string what);
    wait_for_outputs(tally_frames[ch] & 32'h0000_ffff, (tally_flash[ch] >> 4) & 1, what);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Each pulse is 2 cycles high, then 4 to 7 cycles low
  task automatic send_pulses(mipi_rx_pkg::vc_mask_t mask, int count, logic link_ok);
    int                     gap;
    mipi_rx_pkg::mipi_err_t err_word;
    for (int p = 0; p < count; p++)
    begin
      err_word = mipi_rx_pkg::mipi_err_t'($urandom);
      err_word[`MIPI_ERR_OK_BIT] = link_ok;
      gap = 4 + int'($urandom % 4);
      @(posedge mipi_pclk);
      i_err   <= err_word;
      i_vsync <= mask;
      repeat (2) @(posedge mipi_pclk);
      i_vsync <= '0;
      repeat (gap) @(posedge mipi_pclk);
      for (int ch = 0; ch < `MIPI_NUM_VC; ch++)
      begin
        if (link_ok && mask[ch] && i_vc_ena[ch])
        begin
          record_frame(ch);
        end
      end
    end
  endtask

  task automatic select_channel(int ch);
    @(posedge mipi_pclk);
    i_vc_sel <= mipi_rx_pkg::vc_idx_t'(ch);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    // Last edge before this sample still saw reset asserted
    @(negedge mipi_pclk);
    check_value("reset state: o_led2", int'(o_led2), 0);
    check_value("reset state: o_led3", int'(o_led3), 1);
    check_value("reset state: o_frame_count", int'(o_frame_count), 0);
    wait_for_outputs(0, 0, "idle after reset");
  endtask

  task automatic test_count_selected();
    int n;
    n = 5 + int'($urandom % 20);
    select_channel(0);
    send_pulses(mipi_rx_pkg::vc_mask_t'(1), n, 1'b1);
    check_selected(0, "count on channel 0");
  endtask

  task automatic test_error_gating();
    send_pulses(mipi_rx_pkg::vc_mask_t'(1), 3, 1'b0);
    check_selected(0, "pulses with link error");
    send_pulses(mipi_rx_pkg::vc_mask_t'(1), 4, 1'b1);
    check_selected(0, "pulses after link recovery");
  endtask

  task automatic test_disabled_channel();
    @(posedge mipi_pclk);
    i_vc_ena <= 4'b1011;
    select_channel(2);
    send_pulses(4'b0100, 5, 1'b1);
    check_selected(2, "disabled channel 2");
    @(posedge mipi_pclk);
    i_vc_ena <= 4'b1111;
  endtask

  // Channel 1 has seen no pulse so far
  task automatic test_flash_wrap();
    select_channel(1);
    send_pulses(4'b0010, 16, 1'b1);
    check_selected(1, "flash after 16 frames");
    send_pulses(4'b0010, 15, 1'b1);
    check_selected(1, "flash reload after 31 frames");
    send_pulses(4'b0010, 2, 1'b1);
    check_selected(1, "frames past 31");
  endtask

  task automatic test_channel_select();
    int n;
    for (int ch = 0; ch < `MIPI_NUM_VC; ch++)
    begin
      n = 2 + 3 * ch + int'($urandom % 3);
      send_pulses(mipi_rx_pkg::vc_mask_t'(1 << ch), n, 1'b1);
    end
    for (int ch = 0; ch < `MIPI_NUM_VC; ch++)
    begin
      select_channel(ch);
      check_selected(ch, $sformatf("select channel %0d", ch));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    int seed_ret;
    seed_ret      = $urandom(32'h7ecc_137a);
    error_count   = 0;
    timeout_count = 0;
    for (int ch = 0; ch < `MIPI_NUM_VC; ch++)
    begin
      tally_frames[ch] = 0;
      tally_flash[ch]  = 0;
    end
    i_arstn  <= 1'b0;
    i_vsync  <= '0;
    i_hsync  <= '0;
    i_err    <= '0;
    i_vc_ena <= 4'b1111;
    i_vc_sel <= '0;
    repeat (10) @(posedge mipi_pclk);
    i_arstn <= 1'b1;

    test_reset_state();
    test_count_selected();
    test_error_gating();
    test_disabled_channel();
    test_flash_wrap();
    test_channel_select();

    $display("Summary: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
logic/mipi_rx_pkg.sv
logic/vc_ingress.sv
logic/vc_frame_monitor.sv
logic/vc_status_select.sv
logic/mipi_rx_monitor.sv
sim/tb_mipi_rx_monitor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the MIPI receive monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=tb_mipi_rx_monitor
LOG=sim.log

rm -rf obj_dir

verilator --binary --assert --timescale 1ns/10ps \
  --top-module "${TOP}" -f list.f -o "sim_${TOP}"

if ! "./obj_dir/sim_${TOP}" > "${LOG}" 2>&1; then
  cat "${LOG}"
  echo "Simulation exited with an error status"
  exit 1
fi

cat "${LOG}"

if grep -q "Regression failed" "${LOG}"; then
  exit 1
fi

if ! grep -q "Regression passed" "${LOG}"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
